//--- sim.f
+incdir+include
source/router_pkg.sv
source/reg_bus_if.sv
source/lpm_if.sv
source/stream_fifo.sv
source/reg_bus_decode.sv
source/router_regs.sv
source/route_table.sv
source/pkt_forward.sv
source/router_opl.sv
tb/tb_router_opl.sv

//--- Bender.yml
package:
  name: router_opl

sources:
  - include_dirs:
      - include
    files:
      - source/router_pkg.sv
      - source/reg_bus_if.sv
      - source/lpm_if.sv
      - source/stream_fifo.sv
      - source/reg_bus_decode.sv
      - source/router_regs.sv
      - source/route_table.sv
      - source/pkt_forward.sv
      - source/router_opl.sv
      - target: simulation
        files:
          - tb/tb_router_opl.sv

//--- tb/router_cases.txt
# W addr data | R addr expected | P src dst_mac ethertype dst_ip beats expected_port
# Hex except src and beats; expected_port 00 means the packet is dropped
W 001 22334400
W 002 00000011
W 003 22334401
W 004 00000011
W 005 22334402
W 006 00000011
W 200 0A010200
W 201 FFFFFF00
W 202 00000004
W 204 0A010000
W 205 FFFF0000
W 206 00000010
W 208 C0A80000
W 209 FFFF0000
W 009 12345678
R 001 22334400
R 006 00000011
R 201 FFFFFF00
R 206 00000010
R 203 00000000
R 009 00000000
R 0FF 00000000
R 2C0 00000000
P 0 001122334400 0800 0A010205 3 04
P 1 001122334401 0800 0A01FF01 2 10
R 200 0A010200
R 205 FFFF0000
P 2 001122334402 0800 0A010299 4 04
P 0 001122334401 0800 0A010205 3 00
P 1 001122334401 86DD 0A010205 2 00
P 2 001122334402 0800 C0A80001 3 00
R 20A 00000000
P 0 001122334400 0800 0B000001 2 00
P 1 001122334401 0800 0A010205 1 00
P 2 001122334402 0800 0A010301 5 10
R 009 00000001
R 00A 00000001
R 00B 00000002
R 00C 00000005
R 00D 00000004
W 000 00000000
R 009 00000000
R 00C 00000000
R 00D 00000000

//--- tb/tb_router_opl.sv
/*
 * Router output-port lookup testbench
 * Replays register and packet cases from a file, checks every output beat
 */
`timescale 1ns/1ps
`default_nettype none
`include "router_macros.svh"

module tb_router_opl;

  localparam int TIMEOUT = 4000;  // Cycles allowed per wait

  logic                   AXI_ACLK;
  logic                   AXI_RESETN;
  logic [`TDATA_W-1:0]    s_axis_tdata;
  logic [`TSTRB_W-1:0]    s_axis_tstrb;
  logic [`TUSER_W-1:0]    s_axis_tuser;
  logic                   s_axis_tvalid;
  logic                   s_axis_tlast;
  logic                   s_axis_tready;
  logic [`TDATA_W-1:0]    m_axis_tdata;
  logic [`TSTRB_W-1:0]    m_axis_tstrb;
  logic [`TUSER_W-1:0]    m_axis_tuser;
  logic                   m_axis_tvalid;
  logic                   m_axis_tlast;
  logic                   m_axis_tready;
  logic [`REG_ADDR_W-1:0] reg_addr;
  logic [`REG_DATA_W-1:0] reg_wdata;
  logic                   reg_wr;
  logic                   reg_rd;
  logic [`REG_DATA_W-1:0] reg_rdata;
  logic                   reg_ack;

  integer seed;
  integer fd;
  integer code;
  logic [7:0]             op;        // Command letter
  logic [8*120-1:0]       skip_buf;  // Rest of a comment line
  logic [`REG_ADDR_W-1:0] f_addr;
  logic [31:0]            f_data;
  integer                 f_src;
  integer                 f_beats;
  logic [47:0]            f_mac;
  logic [15:0]            f_etype;
  logic [31:0]            f_ip;
  logic [7:0]             f_port;    // Zero means dropped
  logic [31:0]            rd_val;
  logic [31:0]            bp_rnd;

  // Expected output beats, oldest first
  logic [`TDATA_W-1:0] exp_data [$];
  logic [`TSTRB_W-1:0] exp_strb [$];
  logic [`TUSER_W-1:0] exp_user [$];
  logic                exp_last [$];

  // Beat seen at a negedge, checked one negedge later
  logic                cap_valid;
  logic [`TDATA_W-1:0] cap_data;
  logic [`TSTRB_W-1:0] cap_strb;
  logic [`TUSER_W-1:0] cap_user;
  logic                cap_last;

  int n_reg_err;
  int n_beat_err;
  int n_extra;
  int n_missing;
  int n_timeout;
  int n_bad;
  int n_beats;

  router_opl DUT (.*);

  initial begin
    AXI_ACLK = 1'b0;
    forever #20 AXI_ACLK = ~AXI_ACLK;
  end

  function automatic logic [255:0] random_vec();
    logic [255:0] v;
    for (int i = 0; i < 8; i++) v[32*i +: 32] = $random(seed);
    return v;
  endfunction

  task automatic send_beat(input logic [`TDATA_W-1:0] d, input logic [`TSTRB_W-1:0] s,
                           input logic [`TUSER_W-1:0] u, input logic last);
    int t;
    if (n_timeout != 0) return;
    s_axis_tdata  = d;
    s_axis_tstrb  = s;
    s_axis_tuser  = u;
    s_axis_tlast  = last;
    s_axis_tvalid = 1'b1;
    t = 0;
    // tready only moves at posedge, so the negedge view holds for the next edge
    while (!s_axis_tready && t < TIMEOUT) begin
      @(negedge AXI_ACLK);
      t++;
    end
    if (!s_axis_tready) begin
      $display("Timeout: input stream stayed not ready at %0t", $time);
      n_timeout++;
    end else begin
      @(negedge AXI_ACLK);  // Taken at the edge in between
    end
  endtask

  task automatic send_packet(input int src, input logic [47:0] mac, input logic [15:0] etype,
                             input logic [31:0] ip, input int beats, input logic [7:0] port);
    logic [255:0]        r;
    logic [`TDATA_W-1:0] d;
    logic [`TUSER_W-1:0] u;
    logic [`TSTRB_W-1:0] s;
    for (int b = 0; b < beats; b++) begin
      d = random_vec();
      r = random_vec();
      u = r[`TUSER_W-1:0];
      s = $random(seed);
      u[`SRC_PORT_POS +: 8] = 8'd0;
      u[`SRC_PORT_POS + 2*src] = 1'b1;  // One-hot source port
      if (b == 0) begin
        d[255:208] = mac;
        d[159:144] = etype;
        d[15:0]    = ip[31:16];  // IP bytes 30-31
      end
      if (b == 1) d[255:240] = ip[15:0];  // IP bytes 32-33
      if (port != 8'd0) begin
        exp_data.push_back(d);
        exp_strb.push_back(s);
        exp_user.push_back({u[`TUSER_W-1:`DST_PORT_POS+8], port, u[`DST_PORT_POS-1:0]});
        exp_last.push_back(b == beats - 1);
      end
      send_beat(d, s, u, b == beats - 1);
    end
    s_axis_tvalid = 1'b0;
  endtask

  task automatic reg_access(input logic is_wr, input logic [`REG_ADDR_W-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int t;
    rdata = 'x;
    if (n_timeout != 0) return;
    reg_addr  = addr;
    reg_wdata = wdata;
    reg_wr    = is_wr;
    reg_rd    = !is_wr;
    @(negedge AXI_ACLK);
    reg_wr = 1'b0;  // One-cycle strobe
    reg_rd = 1'b0;
    t = 0;
    while (!reg_ack && t < TIMEOUT) begin
      @(negedge AXI_ACLK);
      t++;
    end
    if (!reg_ack) begin
      $display("Timeout: no register acknowledge for address 0x%h", addr);
      n_timeout++;
    end else begin
      rdata = reg_rdata;  // Valid with ack
    end
  endtask

  task automatic check_read(input logic [`REG_ADDR_W-1:0] addr, input logic [31:0] expected);
    logic [31:0] got;
    reg_access(1'b0, addr, 32'd0, got);
    if (n_timeout == 0 && got !== expected) begin
      n_reg_err++;
      $display("** Error at %0t: read of 0x%h returned 0x%h, expected 0x%h",
               $time, addr, got, expected);
    end
  endtask

  // Wait until every expected beat has been seen
  task automatic drain_output();
    int t;
    if (n_timeout != 0) return;
    t = 0;
    while (exp_data.size() != 0 && t < TIMEOUT) begin
      @(negedge AXI_ACLK);
      t++;
    end
    if (exp_data.size() != 0) begin
      $display("Timeout: output did not drain, %0d beats still expected", exp_data.size());
      n_timeout++;
    end
  endtask

  // Output side, random back-pressure and in-order compare
  always @(negedge AXI_ACLK) begin
    if (cap_valid) begin
      cap_valid = 1'b0;
      n_beats++;
      if (exp_data.size() == 0) begin
        n_extra++;
        $display("** Error at %0t: output beat while no beat was expected", $time);
      end else begin
        if (cap_data !== exp_data.pop_front()) begin
          n_beat_err++;
          $display("** Error at %0t: beat %0d data differs", $time, n_beats);
        end
        if (cap_strb !== exp_strb.pop_front()) begin
          n_beat_err++;
          $display("** Error at %0t: beat %0d strobe differs", $time, n_beats);
        end
        if (cap_user !== exp_user[0]) begin
          n_beat_err++;
          $display("** Error at %0t: beat %0d sideband differs, port field 0x%h expected 0x%h",
                   $time, n_beats, cap_user[`DST_PORT_POS +: 8], exp_user[0][`DST_PORT_POS +: 8]);
        end
        void'(exp_user.pop_front());
        if (cap_last !== exp_last.pop_front()) begin
          n_beat_err++;
          $display("** Error at %0t: beat %0d tlast is %b", $time, n_beats, cap_last);
        end
      end
    end
    bp_rnd = $random(seed);
    m_axis_tready = AXI_RESETN && bp_rnd[0];  // About half the cycles
    if (m_axis_tvalid && m_axis_tready) begin
      cap_valid = 1'b1;
      cap_data  = m_axis_tdata;
      cap_strb  = m_axis_tstrb;
      cap_user  = m_axis_tuser;
      cap_last  = m_axis_tlast;
    end
  end

  initial begin
    seed          = 32'hce8cb40c;
    AXI_RESETN    = 1'b0;
    s_axis_tdata  = '0;
    s_axis_tstrb  = '0;
    s_axis_tuser  = '0;
    s_axis_tvalid = 1'b0;
    s_axis_tlast  = 1'b0;
    m_axis_tready = 1'b0;
    reg_addr      = '0;
    reg_wdata     = '0;
    reg_wr        = 1'b0;
    reg_rd        = 1'b0;
    cap_valid     = 1'b0;
    repeat (3) @(posedge AXI_ACLK);
    @(negedge AXI_ACLK);
    AXI_RESETN = 1'b1;

    fd = $fopen("tb/router_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open tb/router_cases.txt");
      n_bad++;
    end
    while (fd != 0 && n_timeout == 0) begin
      code = $fscanf(fd, " %c", op);
      if (code != 1) break;  // End of file
      case (op)
        "#": code = $fgets(skip_buf, fd);
        "W": begin
          code = $fscanf(fd, "%h %h", f_addr, f_data);
          drain_output();  // No table or MAC change under traffic
          reg_access(1'b1, f_addr, f_data, rd_val);
        end
        "R": begin
          code = $fscanf(fd, "%h %h", f_addr, f_data);
          if (!f_addr[`BANK_BIT]) drain_output();  // Counters settle between packets
          check_read(f_addr, f_data);
        end
        "P": begin
          code = $fscanf(fd, "%d %h %h %h %d %h", f_src, f_mac, f_etype, f_ip, f_beats, f_port);
          send_packet(f_src, f_mac, f_etype, f_ip, f_beats, f_port);
        end
        default: begin
          $display("Unknown command '%c' in the cases file", op);
          n_bad++;
        end
      endcase
    end
    drain_output();
    n_missing = exp_data.size();
    $display("Errors: register %0d, beat %0d, unexpected %0d, missing %0d, timeout %0d, file %0d",
             n_reg_err, n_beat_err, n_extra, n_missing, n_timeout, n_bad);
    if (n_beats == 0) $display("No output beats were checked");
    if (n_reg_err + n_beat_err + n_extra + n_missing + n_timeout + n_bad == 0 && n_beats > 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- source/router_opl.sv
/*
 * Router output-port lookup top level
 * Input FIFO, forwarder, route table and register banks
 */
`timescale 1ns/1ps
`default_nettype none
`include "router_macros.svh"

module router_opl (
  input  wire                    AXI_ACLK,
  input  wire                    AXI_RESETN,
  // Stream in
  input  wire  [`TDATA_W-1:0]    s_axis_tdata,
  input  wire  [`TSTRB_W-1:0]    s_axis_tstrb,
  input  wire  [`TUSER_W-1:0]    s_axis_tuser,
  input  wire                    s_axis_tvalid,
  input  wire                    s_axis_tlast,
  output logic                   s_axis_tready,
  // Stream out
  output logic [`TDATA_W-1:0]    m_axis_tdata,
  output logic [`TSTRB_W-1:0]    m_axis_tstrb,
  output logic [`TUSER_W-1:0]    m_axis_tuser,
  output logic                   m_axis_tvalid,
  output logic                   m_axis_tlast,
  input  wire                    m_axis_tready,
  // Host registers
  input  wire  [`REG_ADDR_W-1:0] reg_addr,
  input  wire  [`REG_DATA_W-1:0] reg_wdata,
  input  wire                    reg_wr,
  input  wire                    reg_rd,
  output logic [`REG_DATA_W-1:0] reg_rdata,
  output logic                   reg_ack
);

  import router_pkg::*;

  pkt_events_t                events;
  logic [`FIFO_W-1:0]         fifo_dout;
  logic                       fifo_empty;
  logic                       fifo_rd;
  logic                       fifo_nearly_full;
  logic [`NUM_PORTS-1:0][47:0] port_mac;

  reg_bus_if regs_bus ();   // Bank 0
  reg_bus_if table_bus ();  // Bank 1
  lpm_if     lpm ();

  assign s_axis_tready = !fifo_nearly_full;

  stream_fifo u_in_fifo (
    .AXI_ACLK    (AXI_ACLK),
    .AXI_RESETN  (AXI_RESETN),
    .din         ({s_axis_tlast, s_axis_tuser, s_axis_tstrb, s_axis_tdata}),
    .wr_en       (s_axis_tvalid && s_axis_tready),
    .rd_en       (fifo_rd),
    .dout        (fifo_dout),
    .empty       (fifo_empty),
    .nearly_full (fifo_nearly_full)
  );

  pkt_forward u_fwd (
    .AXI_ACLK      (AXI_ACLK),
    .AXI_RESETN    (AXI_RESETN),
    .fifo_dout     (fifo_dout),
    .fifo_empty    (fifo_empty),
    .fifo_rd       (fifo_rd),
    .port_mac      (port_mac),
    .lpm           (lpm.client),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tstrb  (m_axis_tstrb),
    .m_axis_tuser  (m_axis_tuser),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tlast  (m_axis_tlast),
    .m_axis_tready (m_axis_tready),
    .events        (events)
  );

  route_table u_table (
    .AXI_ACLK   (AXI_ACLK),
    .AXI_RESETN (AXI_RESETN),
    .bus        (table_bus.slave),
    .lpm        (lpm.server)
  );

  router_regs u_regs (
    .AXI_ACLK   (AXI_ACLK),
    .AXI_RESETN (AXI_RESETN),
    .bus        (regs_bus.slave),
    .events     (events),
    .port_mac   (port_mac)
  );

  reg_bus_decode u_decode (
    .AXI_ACLK   (AXI_ACLK),
    .AXI_RESETN (AXI_RESETN),
    .reg_addr   (reg_addr),
    .reg_wdata  (reg_wdata),
    .reg_wr     (reg_wr),
    .reg_rd     (reg_rd),
    .reg_rdata  (reg_rdata),
    .reg_ack    (reg_ack),
    .regs_bus   (regs_bus.master),
    .table_bus  (table_bus.master)
  );

endmodule

`default_nettype wire

//--- source/pkt_forward.sv
/*
 * Packet forwarder
 * Runt, MAC and ethertype checks, route lookup, output-port insertion
 */
`timescale 1ns/1ps
`default_nettype none
`include "router_macros.svh"

module pkt_forward (
  input  wire                          AXI_ACLK,
  input  wire                          AXI_RESETN,
  input  wire  [`FIFO_W-1:0]           fifo_dout,
  input  wire                          fifo_empty,
  output logic                         fifo_rd,
  input  wire  [`NUM_PORTS-1:0][47:0]  port_mac,
  lpm_if.client                        lpm,
  output logic [`TDATA_W-1:0]          m_axis_tdata,
  output logic [`TSTRB_W-1:0]          m_axis_tstrb,
  output logic [`TUSER_W-1:0]          m_axis_tuser,
  output logic                         m_axis_tvalid,
  output logic                         m_axis_tlast,
  input  wire                          m_axis_tready,
  output router_pkg::pkt_events_t      events
);

  import router_pkg::*;

  fwd_state_e          state;
  fwd_state_e          state_next;
  logic [`TDATA_W-1:0] f_data;
  logic [`TSTRB_W-1:0] f_strb;
  logic [`TUSER_W-1:0] f_user;
  logic                f_last;
  logic [`TDATA_W-1:0] hold_data;  // Beat 0
  logic [`TSTRB_W-1:0] hold_strb;
  logic [`TUSER_W-1:0] hold_user;
  logic [7:0]          oq_q;       // Output-port field from lookup
  logic                mac_ok;
  logic                is_ip;

  assign {f_last, f_user, f_strb, f_data} = fifo_dout;

  // Destination MAC against the source port's own MAC
  always_comb begin
    mac_ok = 1'b0;  // No Ethernet source bit fails too
    for (int p = 0; p < `NUM_PORTS; p++) begin
      if (hold_user[`SRC_PORT_POS + 2*p] && hold_data[255:208] == port_mac[p]) mac_ok = 1'b1;
    end
  end

  assign is_ip  = (hold_data[159:144] == `ETH_IP);
  // Dest IP, bytes 30-31 from beat 0, 32-33 from beat 1 still at the head
  assign lpm.ip = {hold_data[15:0], f_data[255:240]};

  // Output mux, held beat 0 first then straight from the FIFO
  assign m_axis_tdata = (state == FWD_SEND_HEAD) ? hold_data : f_data;
  assign m_axis_tstrb = (state == FWD_SEND_HEAD) ? hold_strb : f_strb;
  assign m_axis_tlast = (state == FWD_SEND_HEAD) ? 1'b0 : f_last;  // Beat 0 never last here

  always_comb begin
    m_axis_tuser = (state == FWD_SEND_HEAD) ? hold_user : f_user;
    m_axis_tuser[`DST_PORT_POS +: 8] = oq_q;
  end

  always_comb begin
    state_next    = state;
    fifo_rd       = 1'b0;
    lpm.req       = 1'b0;
    m_axis_tvalid = 1'b0;
    events        = '0;
    case (state)
      FWD_HEAD: begin
        if (!fifo_empty) begin
          fifo_rd = 1'b1;                     // Pop beat 0 into hold
          if (f_last) events.dropped = 1'b1;  // Runt
          else state_next = FWD_SECOND;
        end
      end
      FWD_SECOND: begin
        if (!fifo_empty) begin
          if (!mac_ok) begin
            events.wrong_mac = 1'b1;
            events.dropped   = 1'b1;
            state_next       = FWD_DROP;
          end else if (!is_ip) begin
            events.non_ip  = 1'b1;
            events.dropped = 1'b1;
            state_next     = FWD_DROP;
          end else begin
            lpm.req    = 1'b1;
            state_next = FWD_LOOKUP;
          end
        end
      end
      FWD_LOOKUP: begin
        if (lpm.done) begin
          if (lpm.hit) begin
            state_next = FWD_SEND_HEAD;
          end else begin
            events.lpm_miss = 1'b1;
            events.dropped  = 1'b1;
            state_next      = FWD_DROP;
          end
        end
      end
      FWD_SEND_HEAD: begin
        m_axis_tvalid = 1'b1;
        if (m_axis_tready) state_next = FWD_SEND_BODY;
      end
      FWD_SEND_BODY: begin
        m_axis_tvalid = !fifo_empty;
        fifo_rd       = !fifo_empty && m_axis_tready;
        if (fifo_rd && f_last) begin
          events.forwarded = 1'b1;
          state_next       = FWD_HEAD;
        end
      end
      FWD_DROP: begin
        fifo_rd = !fifo_empty;  // Flush through tlast
        if (fifo_rd && f_last) state_next = FWD_HEAD;
      end
      default: state_next = FWD_HEAD;
    endcase
  end

  always_ff @(posedge AXI_ACLK) begin
    if (!AXI_RESETN) state <= FWD_HEAD;
    else state <= state_next;
  end

  always_ff @(posedge AXI_ACLK) begin
    if (state == FWD_HEAD && fifo_rd) begin
      hold_data <= f_data;
      hold_strb <= f_strb;
      hold_user <= f_user;
    end
    if (state == FWD_LOOKUP && lpm.done) oq_q <= lpm.oq;
  end

endmodule

`default_nettype wire

//--- source/route_table.sv
/*
 * Route table
 * 16 rows of IP, mask and output port, searched one row per clock
 * Host accesses and searches share the rows through a small arbiter
 */
`timescale 1ns/1ps
`default_nettype none
`include "router_macros.svh"

module route_table (
  input wire       AXI_ACLK,
  input wire       AXI_RESETN,
  reg_bus_if.slave bus,
  lpm_if.server    lpm
);

  import router_pkg::*;

  rt_state_e              state;
  reg_op_e                op;      // Strobe this cycle
  reg_op_e                h_op;    // Held strobe, OP_NONE when idle
  reg_op_e                cur_op;
  logic [31:0]            rt_ip   [`RT_DEPTH];
  logic [31:0]            rt_mask [`RT_DEPTH];
  logic [7:0]             rt_oq   [`RT_DEPTH];  // Zero marks an empty row
  logic [`BANK_BIT-1:0]   h_addr;
  logic [`BANK_BIT-1:0]   cur_addr;
  logic [`REG_DATA_W-1:0] h_wdata;
  logic [`REG_DATA_W-1:0] cur_wdata;
  logic [`REG_DATA_W-1:0] rd_word;
  logic [`RT_IDX_W-1:0]   row;     // Search pointer
  logic [`RT_IDX_W-1:0]   cur_row;
  logic [1:0]             cur_col;
  logic                   cur_mapped;
  logic                   s_pend;  // Search request waiting
  logic                   serve;
  logic                   start;
  logic                   match;

  assign op = bus.wr ? OP_WRITE : (bus.rd ? OP_READ : OP_NONE);

  // A held strobe takes precedence over the live one
  assign cur_op    = (h_op != OP_NONE) ? h_op : op;
  assign cur_addr  = (h_op != OP_NONE) ? h_addr : bus.addr;
  assign cur_wdata = (h_op != OP_NONE) ? h_wdata : bus.wdata;

  // Word r*4+c
  assign cur_row    = cur_addr[`RT_IDX_W+1:2];
  assign cur_col    = cur_addr[1:0];
  assign cur_mapped = (cur_addr[`BANK_BIT-1:`RT_IDX_W+2] == '0);

  always_comb begin
    rd_word = '0;
    if (cur_mapped) begin
      case (cur_col)
        2'd0:    rd_word = rt_ip[cur_row];
        2'd1:    rd_word = rt_mask[cur_row];
        2'd2:    rd_word = {24'd0, rt_oq[cur_row]};
        default: rd_word = '0;  // Column 3 unused
      endcase
    end
  end

  // Arbitration
  assign serve = (state == RT_IDLE) && (cur_op != OP_NONE);
  assign start = ((state == RT_IDLE) && !serve || state == RT_HOST) && (lpm.req || s_pend);

  assign match = (rt_oq[row] != '0) && (((lpm.ip ^ rt_ip[row]) & rt_mask[row]) == '0);

  always_ff @(posedge AXI_ACLK) begin
    if (!AXI_RESETN) begin
      state    <= RT_IDLE;
      h_op     <= OP_NONE;
      s_pend   <= 1'b0;
      row      <= '0;
      bus.ack  <= 1'b0;
      lpm.done <= 1'b0;
      for (int r = 0; r < `RT_DEPTH; r++) begin
        rt_ip[r]   <= '0;
        rt_mask[r] <= '0;
        rt_oq[r]   <= '0;
      end
    end else begin
      bus.ack  <= serve;
      lpm.done <= 1'b0;
      if (serve) h_op <= OP_NONE;
      else if (op != OP_NONE) h_op <= op;  // Busy, hold it
      if (start) s_pend <= 1'b0;
      else if (lpm.req) s_pend <= 1'b1;
      if (serve && cur_op == OP_WRITE && cur_mapped) begin
        case (cur_col)
          2'd0:    rt_ip[cur_row] <= cur_wdata;
          2'd1:    rt_mask[cur_row] <= cur_wdata;
          2'd2:    rt_oq[cur_row] <= cur_wdata[7:0];
          default: ;
        endcase
      end
      case (state)
        RT_IDLE: begin
          if (serve) begin
            state <= RT_HOST;
          end else if (start) begin
            state <= RT_SEARCH;
            row   <= '0;
          end
        end
        RT_HOST: begin
          state <= start ? RT_SEARCH : RT_IDLE;
          row   <= '0;
        end
        RT_SEARCH: begin
          // First hit wins, so longest prefixes go in the low rows
          if (match || row == `RT_DEPTH - 1) begin
            lpm.done <= 1'b1;
            state    <= RT_IDLE;
          end else begin
            row <= row + 1'b1;
          end
        end
        default: state <= RT_IDLE;
      endcase
    end
  end

  always_ff @(posedge AXI_ACLK) begin
    if (op != OP_NONE) begin
      h_addr  <= bus.addr;
      h_wdata <= bus.wdata;
    end
    if (serve) bus.rdata <= (cur_op == OP_READ) ? rd_word : '0;
    if (state == RT_SEARCH) begin
      lpm.hit <= match;
      lpm.oq  <= rt_oq[row];
    end
  end

endmodule

`default_nettype wire

//--- source/router_regs.sv
/*
 * Router register bank
 * Port MAC addresses and packet counters, ack one cycle after the strobe
 */
`timescale 1ns/1ps
`default_nettype none
`include "router_macros.svh"

module router_regs (
  input  wire                          AXI_ACLK,
  input  wire                          AXI_RESETN,
  reg_bus_if.slave                     bus,
  input  wire router_pkg::pkt_events_t events,
  output logic [`NUM_PORTS-1:0][47:0]  port_mac
);

  import router_pkg::*;

  reg_op_e                op;
  logic [`REG_DATA_W-1:0] mac_word [2*`NUM_PORTS];  // Low word then high word
  logic [`REG_DATA_W-1:0] cnt [`NUM_CNT];
  logic [`NUM_CNT-1:0]    ev;
  logic [`BANK_BIT-1:0]   mac_off;
  logic [`BANK_BIT-1:0]   cnt_off;
  logic                   is_mac;
  logic                   is_cnt;
  logic [`REG_DATA_W-1:0] rd_word;

  assign op = bus.wr ? OP_WRITE : (bus.rd ? OP_READ : OP_NONE);
  assign ev = events;  // Counter 0 sits at the top bit

  assign mac_off = bus.addr - `BANK_BIT'(`REG_MAC_BASE);
  assign cnt_off = bus.addr - `BANK_BIT'(`REG_CNT_BASE);
  assign is_mac  = (bus.addr >= `REG_MAC_BASE) && (bus.addr < `REG_CNT_BASE);
  assign is_cnt  = (bus.addr >= `REG_CNT_BASE) && (bus.addr < `REG_CNT_BASE + `NUM_CNT);

  always_comb begin
    rd_word = '0;  // Unmapped
    if (is_mac) rd_word = mac_word[mac_off[2:0]];
    else if (is_cnt) rd_word = cnt[cnt_off[2:0]];
  end

  for (genvar p = 0; p < `NUM_PORTS; p++) begin : g_mac
    assign port_mac[p] = {mac_word[2*p+1][15:0], mac_word[2*p]};  // 48 bit address
  end

  always_ff @(posedge AXI_ACLK) begin
    if (!AXI_RESETN) begin
      bus.ack <= 1'b0;
      for (int i = 0; i < 2*`NUM_PORTS; i++) mac_word[i] <= '0;
      for (int i = 0; i < `NUM_CNT; i++) cnt[i] <= '0;
    end else begin
      bus.ack <= (op != OP_NONE);
      // Counter words are read only
      if (op == OP_WRITE && is_mac) mac_word[mac_off[2:0]] <= bus.wdata;
      for (int i = 0; i < `NUM_CNT; i++) begin
        if (op == OP_WRITE && bus.addr == `REG_CLR) cnt[i] <= '0;  // Clear wins
        else if (ev[`NUM_CNT-1-i]) cnt[i] <= cnt[i] + 1'b1;
      end
    end
  end

  always_ff @(posedge AXI_ACLK) begin
    if (op != OP_NONE) bus.rdata <= (op == OP_READ) ? rd_word : '0;
  end

endmodule

`default_nettype wire

//--- source/reg_bus_decode.sv
/*
 * Register port decoder
 * Steers each strobe to the counter bank or the route table bank
 */
`timescale 1ns/1ps
`default_nettype none
`include "router_macros.svh"

module reg_bus_decode (
  input  wire                    AXI_ACLK,
  input  wire                    AXI_RESETN,
  input  wire  [`REG_ADDR_W-1:0] reg_addr,
  input  wire  [`REG_DATA_W-1:0] reg_wdata,
  input  wire                    reg_wr,
  input  wire                    reg_rd,
  output logic [`REG_DATA_W-1:0] reg_rdata,
  output logic                   reg_ack,
  reg_bus_if.master              regs_bus,
  reg_bus_if.master              table_bus
);

  logic is_tbl;  // Bank select of this strobe
  logic sel_q;   // Bank of the access in flight

  assign is_tbl = reg_addr[`BANK_BIT];

  // Offset goes to both, strobe only to one
  assign regs_bus.addr   = reg_addr[`BANK_BIT-1:0];
  assign regs_bus.wdata  = reg_wdata;
  assign regs_bus.wr     = reg_wr && !is_tbl;
  assign regs_bus.rd     = reg_rd && !is_tbl;
  assign table_bus.addr  = reg_addr[`BANK_BIT-1:0];
  assign table_bus.wdata = reg_wdata;
  assign table_bus.wr    = reg_wr && is_tbl;
  assign table_bus.rd    = reg_rd && is_tbl;

  always_ff @(posedge AXI_ACLK) begin
    if (!AXI_RESETN) sel_q <= 1'b0;
    else if (reg_wr || reg_rd) sel_q <= is_tbl;
  end

  // Reply mux, data is zero outside the ack cycle
  assign reg_ack   = sel_q ? table_bus.ack : regs_bus.ack;
  assign reg_rdata = !reg_ack ? '0 : (sel_q ? table_bus.rdata : regs_bus.rdata);

endmodule

`default_nettype wire

//--- source/stream_fifo.sv
/*
 * Input packet FIFO
 * Fall-through, head visible without a pop, nearly_full at one free entry
 */
`timescale 1ns/1ps
`default_nettype none
`include "router_macros.svh"

module stream_fifo (
  input  wire                AXI_ACLK,
  input  wire                AXI_RESETN,
  input  wire  [`FIFO_W-1:0] din,
  input  wire                wr_en,
  input  wire                rd_en,
  output logic [`FIFO_W-1:0] dout,
  output logic               empty,
  output logic               nearly_full
);

  localparam int DEPTH = 1 << `FIFO_DEPTH_BITS;

  logic [`FIFO_W-1:0]         mem [DEPTH];
  logic [`FIFO_DEPTH_BITS-1:0] wr_ptr;
  logic [`FIFO_DEPTH_BITS-1:0] rd_ptr;
  logic [`FIFO_DEPTH_BITS:0]   count;  // One extra bit for full
  logic                        do_wr;
  logic                        do_rd;

  assign do_wr = wr_en && (count != DEPTH);  // Overflow guard
  assign do_rd = rd_en && !empty;

  assign dout        = mem[rd_ptr];  // Head peek
  assign empty       = (count == '0);
  assign nearly_full = (count >= DEPTH - 1);

  always_ff @(posedge AXI_ACLK) begin
    if (do_wr) mem[wr_ptr] <= din;
  end

  always_ff @(posedge AXI_ACLK) begin
    if (!AXI_RESETN) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) wr_ptr <= wr_ptr + 1'b1;
      if (do_rd) rd_ptr <= rd_ptr + 1'b1;
      // Both at once leaves the level alone
      if (do_wr && !do_rd) count <= count + 1'b1;
      else if (do_rd && !do_wr) count <= count - 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- source/lpm_if.sv
/*
 * Route search port
 * Request pulse with held IP, done pulse with hit and output-port field
 */
`timescale 1ns/1ps
`default_nettype none

interface lpm_if;

  logic        req;   // One cycle
  logic [31:0] ip;    // Held until done
  logic        done;  // One cycle
  logic        hit;
  logic [7:0]  oq;    // Output-port field of the winning row

  modport client (output req, ip, input done, hit, oq);
  modport server (input req, ip, output done, hit, oq);

endinterface

`default_nettype wire

//--- source/reg_bus_if.sv
/*
 * Register bank port
 * One-cycle strobe in, one-cycle acknowledge with read data out
 */
`timescale 1ns/1ps
`default_nettype none
`include "router_macros.svh"

interface reg_bus_if;

  logic [`BANK_BIT-1:0]   addr;   // Word offset inside the bank
  logic [`REG_DATA_W-1:0] wdata;
  logic                   wr;     // Write strobe
  logic                   rd;     // Read strobe
  logic [`REG_DATA_W-1:0] rdata;  // Valid with ack
  logic                   ack;

  modport master (output addr, wdata, wr, rd, input rdata, ack);
  modport slave (input addr, wdata, wr, rd, output rdata, ack);

endinterface

`default_nettype wire

//--- source/router_pkg.sv
/*
 * Router output-port lookup shared types
 * FSM states, register opcodes and per-packet event pulses
 */
`default_nettype none

package router_pkg;

  // Forwarder FSM
  typedef enum logic [2:0] {
    FWD_HEAD,       // Wait for beat 0
    FWD_SECOND,     // Beat 1 at FIFO head, run checks
    FWD_LOOKUP,     // Route search in flight
    FWD_SEND_HEAD,  // Present held beat 0
    FWD_SEND_BODY,  // Stream from FIFO through tlast
    FWD_DROP        // Discard through tlast
  } fwd_state_e;

  // Route table arbiter
  typedef enum logic [1:0] {
    RT_IDLE,
    RT_SEARCH,
    RT_HOST
  } rt_state_e;

  // Host access decoded from the strobes
  typedef enum logic [1:0] {
    OP_NONE,
    OP_READ,
    OP_WRITE
  } reg_op_e;

  // One-cycle pulses, wrong_mac is the top bit
  typedef struct packed {
    logic wrong_mac;
    logic non_ip;
    logic lpm_miss;
    logic dropped;
    logic forwarded;
  } pkt_events_t;

endpackage

`default_nettype wire

//--- include/router_macros.svh
/*
 * Router output-port lookup
 * Widths, header field positions, table depth and register map
 */
`ifndef ROUTER_MACROS_SVH
`define ROUTER_MACROS_SVH

// Stream widths
`define TDATA_W 256
`define TUSER_W 128
`define TSTRB_W 32
`define FIFO_W (1 + `TUSER_W + `TSTRB_W + `TDATA_W)  // last, user, strobe, data

// Sideband port fields, 8 bits each
`define SRC_PORT_POS 16
`define DST_PORT_POS 24
`define NUM_PORTS 4                // Ethernet ports, one-hot on even bits

// Route table
`define RT_DEPTH 16
`define RT_IDX_W 4

// Register port
`define REG_ADDR_W 10
`define REG_DATA_W 32
`define BANK_BIT 9                 // Set for the route table bank

// Bank 0 word map
`define REG_CLR 0                  // Write clears all counters
`define REG_MAC_BASE 1             // Low/high pairs, ports 0 to 3
`define REG_CNT_BASE 9             // wrong_mac, non_ip, lpm_miss, dropped, forwarded
`define NUM_CNT 5

`define FIFO_DEPTH_BITS 4
`define ETH_IP 16'h0800

`endif
